/* hdl/core_pkg.sv */
package core_pkg;

    localparam int num_regs = 32;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // Integer operations understood by the execute unit.
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_sll = 4'd5,
        op_srl = 4'd6,
        op_slt = 4'd7,
        op_mul = 4'd8,  // Multi-cycle.
        op_div = 4'd9   // Multi-cycle, unsigned.
    } opcode_t;

    typedef enum logic [1:0] {
        exc_none = 2'd0,
        exc_ine  = 2'd1,  // Illegal instruction.
        exc_sys  = 2'd2   // System call.
    } exception_t;

endpackage

/* hdl/latency_timer.sv */
`timescale 1ns/100ps

module latency_timer (
    input wire         clk,
    input wire         reset,
    input wire         load,
    input wire  [3:0]  value,
    output logic       done
);

logic [3:0]  count;
logic        running;

always_ff @(posedge clk) begin
    if (reset) begin
        running <= 1'b0;
    end
    else if (load) begin
        running <= (value != '0);  // A zero load never fires.
    end
    else if (done) begin
        running <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (load) begin
        count <= value;
    end
    else if (running) begin
        count <= count - 4'd1;
    end
end

// Done flags the cycle whose edge takes the count to zero.
assign done = running && (count == 4'd1);

endmodule

/* hdl/exec_alu.sv */
`timescale 1ns/100ps

module exec_alu import core_pkg::*; (
    input wire  opcode_t  opcode,
    input wire  word_t    src1,
    input wire  word_t    src2,
    output word_t         result
);

logic [4:0]  shamt;
word_t       product;
word_t       quotient;

assign shamt = src2[4:0];
assign product = src1 * src2;  // Low half of the product only.

// Division by zero returns all ones.
assign quotient = (src2 == '0) ? '1 : src1 / src2;

always_comb begin
    case (opcode)
        op_add:  result = src1 + src2;
        op_sub:  result = src1 - src2;
        op_and:  result = src1 & src2;
        op_or:   result = src1 | src2;
        op_xor:  result = src1 ^ src2;
        op_sll:  result = src1 << shamt;
        op_srl:  result = src1 >> shamt;
        op_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
        op_mul:  result = product;
        op_div:  result = quotient;
        default: result = '0;
    endcase
end

endmodule

/* hdl/read_operands.sv */
`timescale 1ns/100ps

module read_operands import core_pkg::*; (
    input wire                clk,
    input wire                reset,

    input wire                flush,
    input wire                allowout,

    input wire                id_ready,
    input wire  word_t        id_pc,
    input wire                id_have_exception,
    input wire  exception_t   id_exception_type,
    input wire  opcode_t      id_opcode,
    input wire  reg_addr_t    id_rf_src1,
    input wire  reg_addr_t    id_rf_src2,
    input wire                id_src2_is_imm,
    input wire  word_t        id_imm,
    input wire  reg_addr_t    id_dest,

    output reg_addr_t         r1_addr,
    input wire                r1_valid,
    input wire  word_t        r1_data,

    output reg_addr_t         r2_addr,
    input wire                r2_valid,
    input wire  word_t        r2_data,

    output logic              ro_valid,
    output logic              ro_ready,
    output word_t             ro_pc,
    output logic              ro_have_exception,
    output exception_t        ro_exception_type,
    output opcode_t           ro_opcode,
    output word_t             ro_src1,
    output word_t             ro_src2,
    output reg_addr_t         ro_dest
);

logic        st_valid;
word_t       st_pc;
logic        st_have_exception;
exception_t  st_exception_type;
opcode_t     st_opcode;
reg_addr_t   st_rf_src1;
reg_addr_t   st_rf_src2;
logic        st_src2_is_imm;
word_t       st_imm;
reg_addr_t   st_dest;

always_ff @(posedge clk) begin
    if (reset || flush) begin
        st_valid <= 1'b0;
    end
    else if (allowout) begin
        st_valid <= id_ready;  // An empty slot is loaded as invalid.
        st_pc <= id_pc;
        st_have_exception <= id_have_exception;
        st_exception_type <= id_exception_type;
        st_opcode <= id_opcode;
        st_rf_src1 <= id_rf_src1;
        st_rf_src2 <= id_rf_src2;
        st_src2_is_imm <= id_src2_is_imm;
        st_imm <= id_imm;
        st_dest <= id_dest;
    end
end

assign r1_addr = st_rf_src1;
assign r2_addr = st_rf_src2;

// An excepting instruction does not wait for its sources.
assign ro_valid = st_valid;
assign ro_ready = st_valid && (r1_valid && r2_valid || st_have_exception);

assign ro_pc = st_pc;
assign ro_have_exception = st_have_exception;
assign ro_exception_type = st_exception_type;
assign ro_opcode = st_opcode;
assign ro_src1 = r1_data;
assign ro_src2 = st_src2_is_imm ? st_imm : r2_data;
assign ro_dest = st_dest;

ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
    ro_ready |-> ro_valid);

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
    input wire                clk,
    input wire                reset,

    input wire  reg_addr_t    r1_addr,
    output word_t             r1_data,
    output logic              r1_valid,

    input wire  reg_addr_t    r2_addr,
    output word_t             r2_data,
    output logic              r2_valid,

    input wire                set_busy,
    input wire  reg_addr_t    busy_addr,

    input wire                wb_en,
    input wire  reg_addr_t    wb_addr,
    input wire  word_t        wb_data
);

word_t                regs [1:num_regs-1];  // Register 0 has no storage.
logic [num_regs-1:0]  busy;

always_ff @(posedge clk) begin
    if (wb_en && wb_addr != '0) begin
        regs[wb_addr] <= wb_data;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        busy <= '0;
    end
    else begin
        if (wb_en && wb_addr != '0) begin
            busy[wb_addr] <= 1'b0;
        end
        if (set_busy && busy_addr != '0) begin
            busy[busy_addr] <= 1'b1;
        end
    end
end

// No bypass, so a write is seen from the cycle after wb_en.
assign r1_data = (r1_addr == '0) ? '0 : regs[r1_addr];
assign r2_data = (r2_addr == '0) ? '0 : regs[r2_addr];

assign r1_valid = !busy[r1_addr];  // Bit 0 never gets set.
assign r2_valid = !busy[r2_addr];

wb_hits_busy: assert property (@(posedge clk) disable iff (reset)
    wb_en |-> busy[wb_addr]);

no_double_busy: assert property (@(posedge clk) disable iff (reset)
    set_busy |-> !busy[busy_addr]);

endmodule

/* hdl/exec_control.sv */
`timescale 1ns/100ps

module exec_control import core_pkg::*; #(
    parameter int mul_latency = 3,
    parameter int div_latency = 8
) (
    input wire                clk,
    input wire                reset,

    input wire                ro_valid,
    input wire                ro_ready,
    input wire  opcode_t      ro_opcode,
    input wire  reg_addr_t    ro_dest,
    input wire  word_t        ro_pc,
    input wire                ro_have_exception,
    input wire  exception_t   ro_exception_type,
    output logic              allowout,

    output opcode_t           alu_opcode,
    input wire  word_t        alu_result,

    output logic              timer_load,
    output logic [3:0]        timer_value,
    input wire                timer_done,

    output logic              set_busy,
    output reg_addr_t         busy_addr,

    output logic              wb_en,
    output reg_addr_t         wb_addr,
    output word_t             wb_data,

    output logic              commit_valid,
    output word_t             commit_pc,
    output reg_addr_t         commit_dest,
    output word_t             commit_data,
    output logic              commit_have_exception,
    output exception_t        commit_exception_type
);

typedef enum logic [1:0] {s_idle, s_wait, s_done} state_t;

localparam logic [3:0] mul_count = 4'(mul_latency - 1);
localparam logic [3:0] div_count = 4'(div_latency - 1);

state_t      state;
logic        started;
logic        issue;
logic        multi;
word_t       pc_q;
reg_addr_t   dest_q;
logic        exc_q;
exception_t  exc_type_q;
word_t       result_q;

assign issue = (state == s_idle) && ro_ready;
assign allowout = started && (!ro_valid || issue);  // Upstream sees this as id_allowin.

// A latency of one behaves like any single-cycle operation.
assign multi = !ro_have_exception &&
               ((ro_opcode == op_mul && mul_latency > 1) ||
                (ro_opcode == op_div && div_latency > 1));

assign alu_opcode = ro_opcode;
assign timer_load = issue && multi;
assign timer_value = (ro_opcode == op_div) ? div_count : mul_count;

assign set_busy = issue && !ro_have_exception && ro_dest != '0;
assign busy_addr = ro_dest;

always_ff @(posedge clk) begin
    if (reset) begin
        state <= s_idle;
        started <= 1'b0;
    end
    else begin
        started <= 1'b1;
        case (state)
            s_idle: if (issue) state <= multi ? s_wait : s_done;
            s_wait: if (timer_done) state <= s_done;
            default: state <= s_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (issue) begin
        pc_q <= ro_pc;
        dest_q <= ro_dest;
        exc_q <= ro_have_exception;
        exc_type_q <= ro_exception_type;
        result_q <= alu_result;  // The timer only models the latency.
    end
end

assign commit_valid = (state == s_done);
assign commit_pc = pc_q;
assign commit_dest = dest_q;
assign commit_data = exc_q ? '0 : result_q;
assign commit_have_exception = exc_q;
assign commit_exception_type = exc_type_q;

assign wb_en = commit_valid && !exc_q && dest_q != '0;
assign wb_addr = dest_q;
assign wb_data = result_q;

done_only_in_wait: assert property (@(posedge clk) disable iff (reset)
    timer_done |-> state == s_wait);

endmodule

/* hdl/operand_core.sv */
`timescale 1ns/100ps

module operand_core import core_pkg::*; #(
    parameter int mul_latency = 3,
    parameter int div_latency = 8
) (
    input wire                clk,
    input wire                reset,
    input wire                flush,

    input wire                id_ready,
    input wire  word_t        id_pc,
    input wire                id_have_exception,
    input wire  exception_t   id_exception_type,
    input wire  opcode_t      id_opcode,
    input wire  reg_addr_t    id_rf_src1,
    input wire  reg_addr_t    id_rf_src2,
    input wire                id_src2_is_imm,
    input wire  word_t        id_imm,
    input wire  reg_addr_t    id_dest,
    output logic              id_allowin,

    output logic              commit_valid,
    output word_t             commit_pc,
    output reg_addr_t         commit_dest,
    output word_t             commit_data,
    output logic              commit_have_exception,
    output exception_t        commit_exception_type
);

reg_addr_t   r1_addr;
reg_addr_t   r2_addr;
word_t       r1_data;
word_t       r2_data;
logic        r1_valid;
logic        r2_valid;
logic        ro_valid;
logic        ro_ready;
word_t       ro_pc;
logic        ro_have_exception;
exception_t  ro_exception_type;
opcode_t     ro_opcode;
word_t       ro_src1;
word_t       ro_src2;
reg_addr_t   ro_dest;
opcode_t     alu_opcode;
word_t       alu_result;
logic        timer_load;
logic [3:0]  timer_value;
logic        timer_done;
logic        set_busy;
reg_addr_t   busy_addr;
logic        wb_en;
reg_addr_t   wb_addr;
word_t       wb_data;

read_operands u_read_operands (
    .clk, .reset, .flush,
    .allowout          (id_allowin),
    .id_ready, .id_pc, .id_have_exception, .id_exception_type, .id_opcode,
    .id_rf_src1, .id_rf_src2, .id_src2_is_imm, .id_imm, .id_dest,
    .r1_addr, .r1_valid, .r1_data,
    .r2_addr, .r2_valid, .r2_data,
    .ro_valid, .ro_ready, .ro_pc, .ro_have_exception, .ro_exception_type,
    .ro_opcode, .ro_src1, .ro_src2, .ro_dest
);

reg_file u_reg_file (
    .clk, .reset,
    .r1_addr, .r1_data, .r1_valid,
    .r2_addr, .r2_data, .r2_valid,
    .set_busy, .busy_addr,
    .wb_en, .wb_addr, .wb_data
);

exec_control #(
    .mul_latency       (mul_latency),
    .div_latency       (div_latency)
) u_exec_control (
    .clk, .reset,
    .ro_valid, .ro_ready, .ro_opcode, .ro_dest, .ro_pc,
    .ro_have_exception, .ro_exception_type,
    .allowout          (id_allowin),
    .alu_opcode, .alu_result,
    .timer_load, .timer_value, .timer_done,
    .set_busy, .busy_addr,
    .wb_en, .wb_addr, .wb_data,
    .commit_valid, .commit_pc, .commit_dest, .commit_data,
    .commit_have_exception, .commit_exception_type
);

latency_timer u_latency_timer (
    .clk, .reset,
    .load              (timer_load),
    .value             (timer_value),
    .done              (timer_done)
);

exec_alu u_exec_alu (
    .opcode            (alu_opcode),
    .src1              (ro_src1),
    .src2              (ro_src2),
    .result            (alu_result)
);

endmodule

/* verif/operand_core_tb.sv */
`timescale 1ns/100ps

module operand_core_tb import core_pkg::*; ();

localparam int mul_latency = 3;
localparam int div_latency = 8;
localparam int n_random = 150;
localparam int n_instr = n_random + 70;  // Directed instructions included.

typedef struct packed {
    word_t       pc;
    reg_addr_t   dest;
    word_t       data;
    logic        exc;
    exception_t  etype;
} commit_t;

logic        clk = 1'b0;
logic        reset = 1'b1;
logic        flush = 1'b0;
logic        id_ready = 1'b0;
word_t       id_pc = '0;
logic        id_have_exception = 1'b0;
exception_t  id_exception_type = exc_none;
opcode_t     id_opcode = op_add;
reg_addr_t   id_rf_src1 = '0;
reg_addr_t   id_rf_src2 = '0;
logic        id_src2_is_imm = 1'b0;
word_t       id_imm = '0;
reg_addr_t   id_dest = '0;
logic        id_allowin;
logic        commit_valid;
word_t       commit_pc;
reg_addr_t   commit_dest;
word_t       commit_data;
logic        commit_have_exception;
exception_t  commit_exception_type;

word_t       shadow [num_regs] = '{default: '0};
commit_t     expected [$];
commit_t     head;
logic        head_valid = 1'b0;
int          n_accepted = 0;
int          n_flushed = 0;
int          n_committed = 0;
logic [31:0] rng = 32'd38;
word_t       pc = 32'h0000_1000;

always #2 clk = ~clk;

operand_core #(
    .mul_latency  (mul_latency),
    .div_latency  (div_latency)
) u_operand_core (.*);

task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
endtask

task automatic value_error(input string name, input word_t got, input word_t want);
    stop_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, want));
endtask

function automatic word_t next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

function automatic word_t alu_model(input opcode_t op, input word_t a, input word_t b);
    case (op)
        op_add:  return a + b;
        op_sub:  return a - b;
        op_and:  return a & b;
        op_or:   return a | b;
        op_xor:  return a ^ b;
        op_sll:  return a << b[4:0];
        op_srl:  return a >> b[4:0];
        op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        op_mul:  return a * b;
        op_div:  return (b == '0) ? 32'hffff_ffff : a / b;
        default: return '0;
    endcase
endfunction

// Present one instruction and hold it until the core takes it.
task automatic send(input opcode_t op, input reg_addr_t rd, input reg_addr_t rs1,
                    input reg_addr_t rs2, input logic use_imm, input word_t imm,
                    input exception_t etype, input logic keep);
    commit_t c;
    logic    taken;
    c.pc = pc;
    c.dest = rd;
    c.exc = (etype != exc_none);
    c.etype = etype;
    c.data = c.exc ? '0 : alu_model(op, shadow[rs1], use_imm ? imm : shadow[rs2]);
    if (keep) begin
        expected.push_back(c);
        if (!c.exc && rd != '0) shadow[rd] = c.data;
    end
    id_ready = 1'b1;
    id_pc = pc;
    id_have_exception = c.exc;
    id_exception_type = etype;
    id_opcode = op;
    id_rf_src1 = rs1;
    id_rf_src2 = rs2;
    id_src2_is_imm = use_imm;
    id_imm = imm;
    id_dest = rd;
    pc = pc + 4;
    taken = 1'b0;
    while (!taken) begin
        @(negedge clk);
        taken = id_allowin;  // Stable for the whole cycle.
        @(posedge clk);
        #0.5;
    end
    id_ready = 1'b0;
    n_accepted++;
endtask

task automatic flush_stage();
    flush = 1'b1;
    @(posedge clk);
    #0.5;
    flush = 1'b0;
    n_flushed++;
endtask

task automatic send_random();
    word_t      r;
    exception_t etype;
    r = next_rand();
    etype = (r[7:4] == 4'd0) ? exc_ine : (r[7:4] == 4'd1) ? exc_sys : exc_none;
    send(opcode_t'(r[3:0] % 10), r[12:8], r[17:13], r[22:18], r[23], next_rand(), etype,
         1'b1);
endtask

always @(posedge clk) begin
    if (!reset && commit_valid) n_committed <= n_committed + 1;
end

// The head is refreshed between edges so the assertions see a settled value.
always @(negedge clk) begin
    head_valid <= (n_committed < expected.size());
    if (n_committed < expected.size()) head <= expected[n_committed];
end

commit_has_entry: assert property (@(posedge clk) disable iff (reset)
    commit_valid |-> head_valid)
    else stop_run("a commit appeared with no instruction left to commit");
pc_matches: assert property (@(posedge clk) disable iff (reset)
    commit_valid && head_valid |-> commit_pc == head.pc)
    else value_error("commit_pc", $sampled(commit_pc), $sampled(head.pc));
dest_matches: assert property (@(posedge clk) disable iff (reset)
    commit_valid && head_valid |-> commit_dest == head.dest)
    else value_error("commit_dest", 32'($sampled(commit_dest)), 32'($sampled(head.dest)));
data_matches: assert property (@(posedge clk) disable iff (reset)
    commit_valid && head_valid |-> commit_data == head.data)
    else value_error("commit_data", $sampled(commit_data), $sampled(head.data));
exc_matches: assert property (@(posedge clk) disable iff (reset)
    commit_valid && head_valid |-> commit_have_exception == head.exc)
    else value_error("commit_have_exception", 32'($sampled(commit_have_exception)),
                     32'($sampled(head.exc)));
type_matches: assert property (@(posedge clk) disable iff (reset)
    commit_valid && head_valid |-> commit_exception_type == head.etype)
    else value_error("commit_exception_type", 32'($sampled(commit_exception_type)),
                     32'($sampled(head.etype)));
in_flight_bound: assert property (@(posedge clk) disable iff (reset)
    n_accepted - n_flushed - n_committed <= 2)
    else stop_run("more than two instructions were in flight");
held_while_full: assert property (@(posedge clk) disable iff (reset)
    n_accepted - n_flushed - n_committed == 2 |-> !id_allowin)
    else stop_run("id_allowin was high with both the stage and execute occupied");

initial begin
    #(4.0 * (n_instr * (div_latency + 4) + 8));
    stop_run("the run timed out before all instructions committed");
end

initial begin
    repeat (4) @(posedge clk);
    #0.5;
    reset = 1'b0;
    assert (!commit_valid && !id_allowin)
        else stop_run("commit_valid or id_allowin was high right after reset");
    @(posedge clk);
    #0.5;
    assert (id_allowin) else stop_run("id_allowin did not rise one cycle after reset");
    for (int i = 1; i < num_regs; i++) begin
        send(op_add, reg_addr_t'(i), '0, '0, 1'b1, next_rand(), exc_none, 1'b1);
    end
    for (int k = 0; k < 10; k++) begin
        send(opcode_t'(k), 5'd20, 5'd3, 5'd4, 1'b0, '0, exc_none, 1'b1);
        send(opcode_t'(k), 5'd21, 5'd5, 5'd0, 1'b1, 32'h13 + k, exc_none, 1'b1);
    end
    send(op_add, 5'd7, 5'd7, 5'd0, 1'b1, 32'd5, exc_none, 1'b1);  // RAW chain on r7.
    send(op_sll, 5'd7, 5'd7, 5'd0, 1'b1, 32'd3, exc_none, 1'b1);
    send(op_sub, 5'd8, 5'd7, 5'd1, 1'b0, '0, exc_none, 1'b1);
    send(op_mul, 5'd9, 5'd7, 5'd8, 1'b0, '0, exc_none, 1'b1);
    send(op_add, 5'd10, 5'd9, 5'd0, 1'b1, 32'd1, exc_none, 1'b1);
    send(op_div, 5'd11, 5'd1, 5'd2, 1'b0, '0, exc_none, 1'b1);
    send(op_div, 5'd12, 5'd11, 5'd0, 1'b0, '0, exc_none, 1'b1);  // Divide by zero.
    send(op_xor, 5'd13, 5'd3, 5'd4, 1'b0, '0, exc_none, 1'b1);
    send(op_mul, 5'd14, 5'd12, 5'd0, 1'b1, 32'd7, exc_none, 1'b1);
    send(op_add, 5'd15, 5'd1, 5'd2, 1'b0, '0, exc_ine, 1'b1);
    send(op_or, 5'd16, 5'd15, 5'd0, 1'b1, '0, exc_none, 1'b1);  // Reads the old r15.
    send(op_sub, 5'd15, 5'd3, 5'd3, 1'b0, '0, exc_sys, 1'b1);
    send(op_div, 5'd17, 5'd5, 5'd6, 1'b0, '0, exc_none, 1'b1);
    send(op_add, 5'd18, 5'd17, 5'd0, 1'b1, 32'd1, exc_none, 1'b0);
    assert (!id_allowin) else stop_run("the stage was not held behind the divide");
    flush_stage();
    send(op_add, 5'd19, 5'd17, 5'd0, 1'b1, 32'd2, exc_none, 1'b1);
    send(op_add, 5'd0, 5'd1, 5'd0, 1'b1, 32'h55, exc_none, 1'b1);
    send(op_or, 5'd22, 5'd0, 5'd0, 1'b0, '0, exc_none, 1'b1);
    repeat (n_random) send_random();
    while (n_committed < expected.size()) @(posedge clk);
    repeat (div_latency + 4) @(posedge clk);
    if (n_committed == expected.size() && n_accepted - n_flushed == n_committed) begin
        $display("all tests passed");
        $finish;
    end
    else begin
        stop_run("the number of commits does not match the instructions sent");
    end
end

endmodule

/* all.f */
hdl/core_pkg.sv
hdl/latency_timer.sv
hdl/exec_alu.sv
hdl/read_operands.sv
hdl/reg_file.sv
hdl/exec_control.sv
hdl/operand_core.sv
verif/operand_core_tb.sv

/* Bender.yml */
package:
  name: operand_core

sources:
  - hdl/core_pkg.sv
  - hdl/latency_timer.sv
  - hdl/exec_alu.sv
  - hdl/read_operands.sv
  - hdl/reg_file.sv
  - hdl/exec_control.sv
  - hdl/operand_core.sv
  - target: test
    files:
      - verif/operand_core_tb.sv
